/* source/trdb_pkg.sv */
// ##############################
// shared encodings for the trace packet priority unit
// format 0 subformat values are not defined here
// since the jump target cache is absent
// ##############################

package trdb_pkg;

    // packet format, 2 bit header field of the te_inst packet
    typedef enum logic [1:0] {
        F_OPT_EXT    = 2'h0,
        F_DIFF_DELTA = 2'h1,
        F_ADDR_ONLY  = 2'h2,
        F_SYNC       = 2'h3
    } trdb_format_e;

    // subformat of a format 3 packet
    typedef enum logic [1:0] {
        SF_START   = 2'h0,
        SF_TRAP    = 2'h1,
        SF_CONTEXT = 2'h2,
        SF_SUPPORT = 2'h3
    } trdb_f_sync_subformat_e;

    // qualification status carried by a support packet
    typedef enum logic [1:0] {
        NO_CHANGE  = 2'h0,
        ENDED_REP  = 2'h1,
        TRACE_LOST = 2'h2,
        ENDED_NTR  = 2'h3
    } qual_status_e;

    // irdepth field width
    // counter size is a log2 value, so size 0 gives a 1 bit field
    function automatic int irdepth_width(int call_counter_size);
        return 2 ** call_counter_size;
    endfunction

endpackage

/* source/trdb_event_if.sv */
// ##############################
// composite event conditions, all level
// signals valid in the same cycle
// ##############################

`timescale 1ns/1ps

interface trdb_event_if;

    // this cycle
    logic tc_exc_only;
    logic tc_ppccd;
    logic tc_resync_br;
    logic tc_er_n;
    logic tc_rpt_br;
    logic tc_f3_sf3;
    // next cycle
    logic nc_exc_only;
    logic nc_ppccd_br;

    modport decode (
        output tc_exc_only, tc_ppccd, tc_resync_br, tc_er_n,
        output tc_rpt_br, tc_f3_sf3, nc_exc_only, nc_ppccd_br
    );

    modport select (
        input tc_exc_only, tc_ppccd, tc_resync_br, tc_er_n,
        input tc_rpt_br, tc_f3_sf3, nc_exc_only, nc_ppccd_br
    );

endinterface

/* source/trdb_packet_if.sv */
// ##############################
// unregistered packet decision
// fields only meaningful with pkt_valid high,
// ended_ntr and ended_rep are driven every cycle
// ##############################

`timescale 1ns/1ps

interface trdb_packet_if;

    logic                            pkt_valid;
    trdb_pkg::trdb_format_e          format;
    trdb_pkg::trdb_f_sync_subformat_e subformat;
    logic                            thaddr;
    logic                            cause_mux;
    logic                            tval_mux;
    logic                            resync_timer_rst;
    // format 1 or 2 chosen
    logic                            addr_pkt;
    // format 3 support chosen
    logic                            support_pkt;
    // history sources for the qual status
    logic                            ended_ntr;
    logic                            ended_rep;

    modport select (
        output pkt_valid, format, subformat, thaddr, cause_mux, tval_mux,
        output resync_timer_rst, addr_pkt, support_pkt, ended_ntr, ended_rep
    );

    modport result (
        input pkt_valid, format, subformat, thaddr, cause_mux, tval_mux,
        input resync_timer_rst, addr_pkt, support_pkt, ended_ntr, ended_rep
    );

endinterface

/* source/trdb_event_decode.sv */
// ##############################
// purely combinational
// context changes are treated as precise,
// imprecise context reporting is not supported
// ##############################

`timescale 1ns/1ps

module trdb_event_decode (
    // this cycle
    input logic tc_exception_i,
    input logic tc_retired_i,
    input logic tc_privchange_i,
    input logic tc_context_change_i,
    input logic tc_max_resync_i,
    input logic tc_branch_map_empty_i,
    input logic tc_branch_map_full_i,
    input logic tc_enc_enabled_i,
    input logic tc_enc_disabled_i,
    input logic tc_opmode_change_i,
    // last cycle
    input logic lc_final_qualified_i,
    // next cycle
    input logic nc_exception_i,
    input logic nc_retired_i,
    input logic nc_privchange_i,
    input logic nc_context_change_i,
    input logic nc_branch_map_empty_i,

    trdb_event_if.decode ev
);

    // exception with no instruction retired alongside
    assign ev.tc_exc_only  = tc_exception_i & ~tc_retired_i;
    assign ev.tc_er_n      = tc_exception_i & tc_retired_i;
    // privilege or precise context change
    assign ev.tc_ppccd     = tc_privchange_i | tc_context_change_i;
    // resync only worth an address packet with pending branches
    assign ev.tc_resync_br = tc_max_resync_i & ~tc_branch_map_empty_i;
    // no misprediction input, so only a full map repeats
    assign ev.tc_rpt_br    = tc_branch_map_full_i;
    // support packet triggers
    assign ev.tc_f3_sf3    = tc_enc_enabled_i | tc_enc_disabled_i | tc_opmode_change_i
                           | lc_final_qualified_i;

    assign ev.nc_exc_only  = nc_exception_i & ~nc_retired_i;
    assign ev.nc_ppccd_br  = (nc_privchange_i | nc_context_change_i) & ~nc_branch_map_empty_i;

endmodule

/* source/trdb_priority_select.sv */
// ##############################
// priority chain of the encoder flowchart
// format 0 is never chosen
// only tc_reported is stored here
// ##############################

`timescale 1ns/1ps

module trdb_priority_select (
    input logic clk_i,
    input logic rst_ni,

    input logic valid_i,
    input logic tc_qualified_i,
    input logic tc_first_qualified_i,
    input logic lc_exception_i,
    input logic lc_updiscon_i,
    input logic tc_max_resync_i,
    input logic tc_branch_map_empty_i,
    input logic nc_qualified_i,

    trdb_event_if.select  ev,
    trdb_packet_if.select pkt
);

    logic                   tc_reported_d, tc_reported_q;
    trdb_pkg::trdb_format_e addr_format;

    // trap already reported in the previous cycle
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            tc_reported_q <= 1'b0;
        end else begin
            tc_reported_q <= tc_reported_d;
        end
    end

    // format 1 if branches are pending, else format 2
    assign addr_format = tc_branch_map_empty_i ? trdb_pkg::F_ADDR_ONLY
                                               : trdb_pkg::F_DIFF_DELTA;

    always_comb begin
        pkt.pkt_valid        = 1'b0;
        pkt.format           = trdb_pkg::F_OPT_EXT;
        pkt.subformat        = trdb_pkg::SF_START;
        pkt.thaddr           = 1'b0;
        pkt.cause_mux        = 1'b0;
        pkt.tval_mux         = 1'b0;
        pkt.resync_timer_rst = 1'b0;
        pkt.addr_pkt         = 1'b0;
        pkt.support_pkt      = 1'b0;
        pkt.ended_ntr        = 1'b0;
        pkt.ended_rep        = 1'b0;
        tc_reported_d        = 1'b0;

        if (valid_i) begin
            if (ev.tc_f3_sf3) begin
                // support packet, independent of qualification
                pkt.pkt_valid   = 1'b1;
                pkt.format      = trdb_pkg::F_SYNC;
                pkt.subformat   = trdb_pkg::SF_SUPPORT;
                pkt.support_pkt = 1'b1;
            end else if (tc_qualified_i) begin
                if (lc_exception_i) begin
                    pkt.pkt_valid        = 1'b1;
                    pkt.format           = trdb_pkg::F_SYNC;
                    pkt.resync_timer_rst = 1'b1;
                    if (ev.tc_exc_only) begin
                        // back to back exception, trap packet without address
                        pkt.subformat = trdb_pkg::SF_TRAP;
                        tc_reported_d = 1'b1;
                    end else if (tc_reported_q) begin
                        pkt.subformat = trdb_pkg::SF_START;
                    end else begin
                        // handler address goes with the trap
                        pkt.subformat = trdb_pkg::SF_TRAP;
                        pkt.thaddr    = 1'b1;
                    end
                end else if (tc_first_qualified_i || ev.tc_ppccd || tc_max_resync_i) begin
                    pkt.pkt_valid        = 1'b1;
                    pkt.format           = trdb_pkg::F_SYNC;
                    pkt.subformat        = trdb_pkg::SF_START;
                    pkt.resync_timer_rst = 1'b1;
                end else if (lc_updiscon_i) begin
                    pkt.pkt_valid = 1'b1;
                    pkt.ended_ntr = 1'b1;
                    if (ev.tc_exc_only) begin
                        // cause and tval come from this cycle
                        pkt.format           = trdb_pkg::F_SYNC;
                        pkt.subformat        = trdb_pkg::SF_TRAP;
                        pkt.resync_timer_rst = 1'b1;
                        pkt.cause_mux        = 1'b1;
                        pkt.tval_mux         = 1'b1;
                    end else begin
                        pkt.format   = addr_format;
                        pkt.addr_pkt = 1'b1;
                    end
                end else if (ev.tc_resync_br || ev.tc_er_n) begin
                    pkt.pkt_valid = 1'b1;
                    pkt.format    = addr_format;
                    pkt.addr_pkt  = 1'b1;
                end else if (ev.nc_exc_only || ev.nc_ppccd_br || !nc_qualified_i) begin
                    // last qualified instruction before a gap
                    pkt.pkt_valid = 1'b1;
                    pkt.format    = addr_format;
                    pkt.addr_pkt  = 1'b1;
                    pkt.ended_rep = !nc_qualified_i;
                end else if (ev.tc_rpt_br) begin
                    pkt.pkt_valid = 1'b1;
                    pkt.format    = trdb_pkg::F_DIFF_DELTA;
                    pkt.addr_pkt  = 1'b1;
                end
            end
        end
    end

endmodule

/* source/trdb_packet_result.sv */
// ##############################
// registered outputs, one cycle after the decision
// implicit return mode itself is not supported,
// irreport and irdepth only copy lc_updiscon
// ##############################

`timescale 1ns/1ps

module trdb_packet_result #(
    parameter int CALL_COUNTER_SIZE = 0,
    parameter int RETURN_STACK_SIZE = 0
) (
    input logic clk_i,
    input logic rst_ni,

    input logic implicit_return_i,
    input logic lc_updiscon_i,

    trdb_packet_if.result pkt,

    output logic                                   valid_o,
    output trdb_pkg::trdb_format_e                 packet_format_o,
    output trdb_pkg::trdb_f_sync_subformat_e       packet_f_sync_subformat_o,
    output logic                                   thaddr_o,
    output logic                                   cause_mux_o,
    output logic                                   tval_mux_o,
    output logic                                   resync_timer_rst_o,
    output trdb_pkg::qual_status_e                 qual_status_o,
    output logic                                   irreport_o,
    output logic [trdb_pkg::irdepth_width(CALL_COUNTER_SIZE)-1:0] irdepth_o
);

    localparam int IrDepthW = trdb_pkg::irdepth_width(CALL_COUNTER_SIZE);

    logic                  lc_ended_ntr_q, lc_ended_rep_q;
    logic                  ir_copy;
    logic                  irreport_d;
    logic [IrDepthW-1:0]   irdepth_d;
    trdb_pkg::qual_status_e qual_status_d;

    // updiscon is copied unless a real return stack would be needed
    assign ir_copy = pkt.addr_pkt && !implicit_return_i
                     && (CALL_COUNTER_SIZE == 0 || RETURN_STACK_SIZE == 0);

    always_comb begin
        irreport_d    = ir_copy & lc_updiscon_i;
        irdepth_d     = '0;
        irdepth_d[0]  = ir_copy & lc_updiscon_i;
        // ntr ending takes precedence over rep ending
        qual_status_d = trdb_pkg::NO_CHANGE;
        if (pkt.support_pkt) begin
            if (lc_ended_ntr_q) begin
                qual_status_d = trdb_pkg::ENDED_NTR;
            end else if (lc_ended_rep_q) begin
                qual_status_d = trdb_pkg::ENDED_REP;
            end
        end
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            lc_ended_ntr_q            <= 1'b0;
            lc_ended_rep_q            <= 1'b0;
            valid_o                   <= 1'b0;
            packet_format_o           <= trdb_pkg::F_OPT_EXT;
            packet_f_sync_subformat_o <= trdb_pkg::SF_START;
            thaddr_o                  <= 1'b0;
            cause_mux_o               <= 1'b0;
            tval_mux_o                <= 1'b0;
            resync_timer_rst_o        <= 1'b0;
            qual_status_o             <= trdb_pkg::NO_CHANGE;
            irreport_o                <= 1'b0;
            irdepth_o                 <= '0;
        end else begin
            // history of the previous decision
            lc_ended_ntr_q            <= pkt.ended_ntr;
            lc_ended_rep_q            <= pkt.ended_rep;
            valid_o                   <= pkt.pkt_valid;
            packet_format_o           <= pkt.format;
            packet_f_sync_subformat_o <= pkt.subformat;
            thaddr_o                  <= pkt.thaddr;
            cause_mux_o               <= pkt.cause_mux;
            tval_mux_o                <= pkt.tval_mux;
            resync_timer_rst_o        <= pkt.resync_timer_rst;
            qual_status_o             <= qual_status_d;
            irreport_o                <= irreport_d;
            irdepth_o                 <= irdepth_d;
        end
    end

endmodule

/* source/trdb_priority.sv */
// ##############################
// packet priority unit top
// outputs lag their event by one cycle
// no back-pressure, emitter takes every packet
// ##############################

`timescale 1ns/1ps

module trdb_priority #(
    parameter int CALL_COUNTER_SIZE = 0,
    parameter int RETURN_STACK_SIZE = 0
) (
    input logic clk_i,
    input logic rst_ni,

    input logic valid_i,
    // last cycle
    input logic lc_exception_i,
    input logic lc_updiscon_i,
    input logic lc_final_qualified_i,
    // this cycle
    input logic tc_qualified_i,
    input logic tc_exception_i,
    input logic tc_retired_i,
    input logic tc_first_qualified_i,
    input logic tc_privchange_i,
    input logic tc_context_change_i,
    input logic tc_max_resync_i,
    input logic tc_branch_map_empty_i,
    input logic tc_branch_map_full_i,
    input logic tc_enc_enabled_i,
    input logic tc_enc_disabled_i,
    input logic tc_opmode_change_i,
    // next cycle
    input logic nc_exception_i,
    input logic nc_retired_i,
    input logic nc_privchange_i,
    input logic nc_context_change_i,
    input logic nc_branch_map_empty_i,
    input logic nc_qualified_i,
    input logic implicit_return_i,

    output logic                                   valid_o,
    output trdb_pkg::trdb_format_e                 packet_format_o,
    output trdb_pkg::trdb_f_sync_subformat_e       packet_f_sync_subformat_o,
    output logic                                   thaddr_o,
    output logic                                   cause_mux_o,
    output logic                                   tval_mux_o,
    output logic                                   resync_timer_rst_o,
    output trdb_pkg::qual_status_e                 qual_status_o,
    output logic                                   irreport_o,
    output logic [trdb_pkg::irdepth_width(CALL_COUNTER_SIZE)-1:0] irdepth_o
);

    trdb_event_if  ev_if ();
    trdb_packet_if pkt_if ();

    // raw events to flowchart conditions
    trdb_event_decode trdb_event_decode_inst (
        .tc_exception_i        (tc_exception_i),
        .tc_retired_i          (tc_retired_i),
        .tc_privchange_i       (tc_privchange_i),
        .tc_context_change_i   (tc_context_change_i),
        .tc_max_resync_i       (tc_max_resync_i),
        .tc_branch_map_empty_i (tc_branch_map_empty_i),
        .tc_branch_map_full_i  (tc_branch_map_full_i),
        .tc_enc_enabled_i      (tc_enc_enabled_i),
        .tc_enc_disabled_i     (tc_enc_disabled_i),
        .tc_opmode_change_i    (tc_opmode_change_i),
        .lc_final_qualified_i  (lc_final_qualified_i),
        .nc_exception_i        (nc_exception_i),
        .nc_retired_i          (nc_retired_i),
        .nc_privchange_i       (nc_privchange_i),
        .nc_context_change_i   (nc_context_change_i),
        .nc_branch_map_empty_i (nc_branch_map_empty_i),
        .ev                    (ev_if.decode)
    );

    trdb_priority_select trdb_priority_select_inst (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .valid_i               (valid_i),
        .tc_qualified_i        (tc_qualified_i),
        .tc_first_qualified_i  (tc_first_qualified_i),
        .lc_exception_i        (lc_exception_i),
        .lc_updiscon_i         (lc_updiscon_i),
        .tc_max_resync_i       (tc_max_resync_i),
        .tc_branch_map_empty_i (tc_branch_map_empty_i),
        .nc_qualified_i        (nc_qualified_i),
        .ev                    (ev_if.select),
        .pkt                   (pkt_if.select)
    );

    // output register stage
    trdb_packet_result #(
        .CALL_COUNTER_SIZE (CALL_COUNTER_SIZE),
        .RETURN_STACK_SIZE (RETURN_STACK_SIZE)
    ) trdb_packet_result_inst (
        .clk_i                     (clk_i),
        .rst_ni                    (rst_ni),
        .implicit_return_i         (implicit_return_i),
        .lc_updiscon_i             (lc_updiscon_i),
        .pkt                       (pkt_if.result),
        .valid_o                   (valid_o),
        .packet_format_o           (packet_format_o),
        .packet_f_sync_subformat_o (packet_f_sync_subformat_o),
        .thaddr_o                  (thaddr_o),
        .cause_mux_o               (cause_mux_o),
        .tval_mux_o                (tval_mux_o),
        .resync_timer_rst_o        (resync_timer_rst_o),
        .qual_status_o             (qual_status_o),
        .irreport_o                (irreport_o),
        .irdepth_o                 (irdepth_o)
    );

endmodule

/* tb/trdb_priority_tb.sv */
// ##############################
// testbench for the packet priority unit
// both size parameters at 0, so irdepth is 1 bit
// one table row per cycle, checked one cycle later
// ##############################

`timescale 1ns/1ps

module trdb_priority_tb;

    localparam int IR_W          = trdb_pkg::irdepth_width(0);
    localparam int RESET_TIMEOUT = 20;

    // stimulus bit positions in a table row
    localparam logic [22:0] VLD = 23'd1 << 0;
    localparam logic [22:0] LCX = 23'd1 << 1;
    localparam logic [22:0] LCU = 23'd1 << 2;
    localparam logic [22:0] LFQ = 23'd1 << 3;
    localparam logic [22:0] TQ  = 23'd1 << 4;
    localparam logic [22:0] TCX = 23'd1 << 5;
    localparam logic [22:0] RET = 23'd1 << 6;
    localparam logic [22:0] FQ  = 23'd1 << 7;
    localparam logic [22:0] PRV = 23'd1 << 8;
    localparam logic [22:0] CTX = 23'd1 << 9;
    localparam logic [22:0] RSY = 23'd1 << 10;
    localparam logic [22:0] BME = 23'd1 << 11;
    localparam logic [22:0] BMF = 23'd1 << 12;
    localparam logic [22:0] ENA = 23'd1 << 13;
    localparam logic [22:0] DIS = 23'd1 << 14;
    localparam logic [22:0] OPM = 23'd1 << 15;
    localparam logic [22:0] NCX = 23'd1 << 16;
    localparam logic [22:0] NRT = 23'd1 << 17;
    localparam logic [22:0] NPR = 23'd1 << 18;
    localparam logic [22:0] NCC = 23'd1 << 19;
    localparam logic [22:0] NBE = 23'd1 << 20;
    localparam logic [22:0] NQ  = 23'd1 << 21;
    localparam logic [22:0] IMR = 23'd1 << 22;

    // expected single bit outputs
    localparam logic [5:0] E_VLD = 6'd1;
    localparam logic [5:0] E_TH  = 6'd2;
    localparam logic [5:0] E_CM  = 6'd4;
    localparam logic [5:0] E_TV  = 6'd8;
    localparam logic [5:0] E_RR  = 6'd16;
    localparam logic [5:0] E_IR  = 6'd32;

    // short names for the table
    localparam trdb_pkg::trdb_format_e           OPT   = trdb_pkg::F_OPT_EXT;
    localparam trdb_pkg::trdb_format_e           DIFF  = trdb_pkg::F_DIFF_DELTA;
    localparam trdb_pkg::trdb_format_e           ADDR  = trdb_pkg::F_ADDR_ONLY;
    localparam trdb_pkg::trdb_format_e           SYNC  = trdb_pkg::F_SYNC;
    localparam trdb_pkg::trdb_f_sync_subformat_e START = trdb_pkg::SF_START;
    localparam trdb_pkg::trdb_f_sync_subformat_e TRAP  = trdb_pkg::SF_TRAP;
    localparam trdb_pkg::trdb_f_sync_subformat_e SUPP  = trdb_pkg::SF_SUPPORT;
    localparam trdb_pkg::qual_status_e           NOCH  = trdb_pkg::NO_CHANGE;
    localparam trdb_pkg::qual_status_e           EREP  = trdb_pkg::ENDED_REP;
    localparam trdb_pkg::qual_status_e           ENTR  = trdb_pkg::ENDED_NTR;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic valid_i, lc_exception_i, lc_updiscon_i, lc_final_qualified_i;
    logic tc_qualified_i, tc_exception_i, tc_retired_i, tc_first_qualified_i;
    logic tc_privchange_i, tc_context_change_i, tc_max_resync_i;
    logic tc_branch_map_empty_i, tc_branch_map_full_i;
    logic tc_enc_enabled_i, tc_enc_disabled_i, tc_opmode_change_i;
    logic nc_exception_i, nc_retired_i, nc_privchange_i, nc_context_change_i;
    logic nc_branch_map_empty_i, nc_qualified_i, implicit_return_i;

    logic                             valid_o;
    trdb_pkg::trdb_format_e           packet_format_o;
    trdb_pkg::trdb_f_sync_subformat_e packet_f_sync_subformat_o;
    logic                             thaddr_o, cause_mux_o, tval_mux_o;
    logic                             resync_timer_rst_o, irreport_o;
    trdb_pkg::qual_status_e           qual_status_o;
    logic [IR_W-1:0]                  irdepth_o;

    // table columns
    logic [22:0]                      stim_q[$];
    logic [5:0]                       flag_q[$];
    trdb_pkg::trdb_format_e           fmt_q[$];
    trdb_pkg::trdb_f_sync_subformat_e sub_q[$];
    trdb_pkg::qual_status_e           qual_q[$];
    logic [IR_W-1:0]                  depth_q[$];

    trdb_priority #(
        .CALL_COUNTER_SIZE (0),
        .RETURN_STACK_SIZE (0)
    ) trdb_priority_inst (.*);

    // 8 ns period
    always #4 clk_i = ~clk_i;

    initial begin
        rst_ni = 1'b0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_format(input trdb_pkg::trdb_format_e act,
                                input trdb_pkg::trdb_format_e exp);
        if (act !== exp) begin
            $display("** Error at %0t: packet_format_o expected %s got %s",
                     $time, exp.name(), act.name());
            abort_run();
        end
    endtask

    task automatic check_subformat(input trdb_pkg::trdb_f_sync_subformat_e act,
                                   input trdb_pkg::trdb_f_sync_subformat_e exp);
        if (act !== exp) begin
            $display("** Error at %0t: packet_f_sync_subformat_o expected %s got %s",
                     $time, exp.name(), act.name());
            abort_run();
        end
    endtask

    task automatic check_qual(input trdb_pkg::qual_status_e act,
                              input trdb_pkg::qual_status_e exp);
        if (act !== exp) begin
            $display("** Error at %0t: qual_status_o expected %s got %s",
                     $time, exp.name(), act.name());
            abort_run();
        end
    endtask

    task automatic check_depth(input logic [IR_W-1:0] act, input logic [IR_W-1:0] exp);
        if (act !== exp) begin
            $display("** Error at %0t: irdepth_o expected %h got %h", $time, exp, act);
            abort_run();
        end
    endtask

    task automatic check_outputs(input logic [5:0] flags,
                                 input trdb_pkg::trdb_format_e fmt,
                                 input trdb_pkg::trdb_f_sync_subformat_e sub,
                                 input trdb_pkg::qual_status_e qual,
                                 input logic [IR_W-1:0] depth);
        check_bit("valid_o", valid_o, flags[0]);
        check_format(packet_format_o, fmt);
        check_subformat(packet_f_sync_subformat_o, sub);
        check_bit("thaddr_o", thaddr_o, flags[1]);
        check_bit("cause_mux_o", cause_mux_o, flags[2]);
        check_bit("tval_mux_o", tval_mux_o, flags[3]);
        check_bit("resync_timer_rst_o", resync_timer_rst_o, flags[4]);
        check_qual(qual_status_o, qual);
        check_bit("irreport_o", irreport_o, flags[5]);
        check_depth(irdepth_o, depth);
    endtask

    task automatic add_row(input logic [22:0] stim, input logic [5:0] flags,
                           input trdb_pkg::trdb_format_e fmt,
                           input trdb_pkg::trdb_f_sync_subformat_e sub,
                           input trdb_pkg::qual_status_e qual,
                           input logic [IR_W-1:0] depth);
        stim_q.push_back(stim);
        flag_q.push_back(flags);
        fmt_q.push_back(fmt);
        sub_q.push_back(sub);
        qual_q.push_back(qual);
        depth_q.push_back(depth);
    endtask

    task automatic apply_stim(input logic [22:0] stim);
        {implicit_return_i, nc_qualified_i, nc_branch_map_empty_i, nc_context_change_i,
         nc_privchange_i, nc_retired_i, nc_exception_i, tc_opmode_change_i,
         tc_enc_disabled_i, tc_enc_enabled_i, tc_branch_map_full_i, tc_branch_map_empty_i,
         tc_max_resync_i, tc_context_change_i, tc_privchange_i, tc_first_qualified_i,
         tc_retired_i, tc_exception_i, tc_qualified_i, lc_final_qualified_i,
         lc_updiscon_i, lc_exception_i, valid_i} = stim;
    endtask

    task automatic check_row(input int i);
        check_outputs(flag_q[i], fmt_q[i], sub_q[i], qual_q[i], depth_q[i]);
    endtask

    task automatic build_table();
        // idle and gating by valid_i
        add_row(23'd0, 6'd0, OPT, START, NOCH, 1'b0);
        add_row(ENA|TQ|NQ, 6'd0, OPT, START, NOCH, 1'b0);
        add_row(VLD|TQ|NQ|BME, 6'd0, OPT, START, NOCH, 1'b0);
        // support beats a pending exception
        add_row(VLD|ENA|LCX|TQ|NQ|BME, E_VLD, SYNC, SUPP, NOCH, 1'b0);
        add_row(VLD|TQ|FQ|NQ|BME, E_VLD|E_RR, SYNC, START, NOCH, 1'b0);
        add_row(VLD|TQ|NQ|BMF, E_VLD, DIFF, START, NOCH, 1'b0);
        // unqualified, no support event
        add_row(VLD|LCX|NQ|BME, 6'd0, OPT, START, NOCH, 1'b0);
        // exception sequence, trap then start then trap with address
        add_row(VLD|TQ|NQ|LCX|TCX|BME, E_VLD|E_RR, SYNC, TRAP, NOCH, 1'b0);
        add_row(VLD|TQ|NQ|LCX|BME, E_VLD|E_RR, SYNC, START, NOCH, 1'b0);
        add_row(VLD|TQ|NQ|BME, 6'd0, OPT, START, NOCH, 1'b0);
        add_row(VLD|TQ|NQ|LCX|BME, E_VLD|E_TH|E_RR, SYNC, TRAP, NOCH, 1'b0);
        // updiscon cases
        add_row(VLD|TQ|NQ|LCU|TCX|BME, E_VLD|E_CM|E_TV|E_RR, SYNC, TRAP, NOCH, 1'b0);
        add_row(VLD|TQ|NQ|ENA, E_VLD, SYNC, SUPP, ENTR, 1'b0);
        add_row(VLD|TQ|NQ|LCU|BME, E_VLD|E_IR, ADDR, START, NOCH, 1'b1);
        add_row(VLD|TQ|NQ|LCU, E_VLD|E_IR, DIFF, START, NOCH, 1'b1);
        // implicit return on, no report
        add_row(VLD|TQ|NQ|LCU|BME|IMR, E_VLD, ADDR, START, NOCH, 1'b0);
        add_row(VLD|OPM, E_VLD, SYNC, SUPP, ENTR, 1'b0);
        // next cycle unqualified
        add_row(VLD|TQ|BME, E_VLD, ADDR, START, NOCH, 1'b0);
        add_row(VLD|DIS, E_VLD, SYNC, SUPP, EREP, 1'b0);
        add_row(VLD|LFQ, E_VLD, SYNC, SUPP, NOCH, 1'b0);
        // privilege, context and resync starts
        add_row(VLD|TQ|NQ|PRV|BME, E_VLD|E_RR, SYNC, START, NOCH, 1'b0);
        add_row(VLD|TQ|NQ|CTX|BME, E_VLD|E_RR, SYNC, START, NOCH, 1'b0);
        add_row(VLD|TQ|NQ|RSY|BME, E_VLD|E_RR, SYNC, START, NOCH, 1'b0);
        // exception with retirement, then next cycle events
        add_row(VLD|TQ|NQ|TCX|RET|BME, E_VLD, ADDR, START, NOCH, 1'b0);
        add_row(VLD|TQ|NQ|NCX, E_VLD, DIFF, START, NOCH, 1'b0);
        add_row(VLD|TQ|NQ|NCX|NRT|BME, 6'd0, OPT, START, NOCH, 1'b0);
        add_row(VLD|TQ|NQ|NPR|BME, E_VLD, ADDR, START, NOCH, 1'b0);
        add_row(VLD|TQ|NQ|NCC|NBE|BME, 6'd0, OPT, START, NOCH, 1'b0);
        add_row(23'd0, 6'd0, OPT, START, NOCH, 1'b0);
    endtask

    initial begin
        int cycles;

        apply_stim(23'd0);
        build_table();

        // reset values held while in reset
        cycles = 0;
        while (rst_ni !== 1'b1) begin
            @(negedge clk_i);
            check_outputs(6'd0, OPT, START, NOCH, '0);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                $display("reset was not released within %0d cycles", RESET_TIMEOUT);
                abort_run();
            end
        end

        // drive row i, check row i-1 at the same falling edge
        for (int i = 0; i < stim_q.size(); i++) begin
            @(negedge clk_i);
            if (i > 0) begin
                check_row(i - 1);
            end
            apply_stim(stim_q[i]);
        end
        @(negedge clk_i);
        check_row(stim_q.size() - 1);

        $display("all tests passed");
        $finish;
    end

endmodule

/* list.f */
source/trdb_pkg.sv
source/trdb_event_if.sv
source/trdb_packet_if.sv
source/trdb_event_decode.sv
source/trdb_priority_select.sv
source/trdb_packet_result.sv
source/trdb_priority.sv
tb/trdb_priority_tb.sv

/* Bender.yml */
package:
  name: trdb_priority

sources:
  - files:
      - source/trdb_pkg.sv
      - source/trdb_event_if.sv
      - source/trdb_packet_if.sv
      - source/trdb_event_decode.sv
      - source/trdb_priority_select.sv
      - source/trdb_packet_result.sv
      - source/trdb_priority.sv
  - target: simulation
    files:
      - tb/trdb_priority_tb.sv
